// ==== design/niuPkg.sv ====
`default_nettype none

package niuPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regIdxT;
    typedef logic [16:0] immT;

    // Primary opcode in ir[31:27]
    typedef enum logic [4:0] {
        opAlu  = 5'b00000,   // Register ops, secondary field selects
        opAddi = 5'b00001,
        opMlti = 5'b00010,
        opAndi = 5'b00101,
        opOri  = 5'b00110,
        opXori = 5'b00111,
        opSuli = 5'b01000,
        opSsli = 5'b01001,
        opSuri = 5'b01010,
        opSsri = 5'b01011,
        opLw   = 5'b10000,
        opSw   = 5'b10011,
        opBeq  = 5'b11000,
        opBne  = 5'b11001,
        opBlt  = 5'b11010,
        opBle  = 5'b11011,
        opJal  = 5'b11111
    } opcodeT;

    // Secondary function in ir[4:0]; immediate opcodes share these codes
    typedef enum logic [4:0] {
        fnSub = 5'b00000,
        fnAdd = 5'b00001,
        fnMlt = 5'b00010,
        fnNot = 5'b00100,
        fnAnd = 5'b00101,
        fnOr  = 5'b00110,
        fnXor = 5'b00111,
        fnSul = 5'b01000,
        fnSsl = 5'b01001,
        fnSur = 5'b01010,
        fnSsr = 5'b01011,
        fnEq  = 5'b10000,
        fnNeq = 5'b10001,
        fnLt  = 5'b10010,
        fnLeq = 5'b10011
    } aluFuncT;

    // Source driving the internal bus
    typedef enum logic [2:0] {
        busNone, busPc, busReg, busImm, busImmSh, busAlu, busMdr
    } busSrcT;

    localparam wordT instrBytes = 32'd4;
    localparam wordT pcStart    = 32'h0000_0000;
    localparam wordT ioAddr     = 32'hFFFF_0020;   // Output port

endpackage

`default_nettype wire

// ==== design/niuCtrlIf.sv ====
`timescale 1ns/100ps
`default_nettype none

interface niuCtrlIf import niuPkg::*; ;
    logic    loadPc;
    logic    incPc;
    logic    loadIr;
    logic    loadA;
    logic    loadB;
    busSrcT  busSel;
    regIdxT  regSel;
    logic    regWrite;
    aluFuncT aluFunc;
    logic    loadMar;
    logic    memWrite;
    wordT    ir;
    logic    cond;   // Bit 0 of ALU result

    modport control (
        output loadPc, incPc, loadIr, loadA, loadB, busSel, regSel, regWrite,
               aluFunc, loadMar, memWrite,
        input  ir, cond
    );

    modport datapath (
        input  loadPc, incPc, loadIr, loadA, loadB, busSel, regSel, regWrite,
               aluFunc, loadMar, memWrite,
        output ir, cond
    );
endinterface

`default_nettype wire

// ==== design/niuMemIf.sv ====
`timescale 1ns/100ps
`default_nettype none

interface niuMemIf import niuPkg::*; ;
    wordT pc;
    wordT bus;
    logic loadMar;
    logic memWrite;
    wordT instr;   // imem word at pc
    wordT mdr;

    modport datapath (
        output pc, bus, loadMar, memWrite,
        input  instr, mdr
    );

    modport memory (
        input  pc, bus, loadMar, memWrite,
        output instr, mdr
    );
endinterface

`default_nettype wire

// ==== design/niuAlu.sv ====
`timescale 1ns/100ps
`default_nettype none

module niuAlu import niuPkg::*; (
    input  wire wordT    a,
    input  wire wordT    b,
    input  wire aluFuncT func,
    output wordT         result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (func)
            fnSub: result = a - b;
            fnAdd: result = a + b;
            fnMlt: result = wordT'($signed(a) * $signed(b));
            fnNot: result = ~a;   // b unused
            fnAnd: result = a & b;
            fnOr:  result = a | b;
            fnXor: result = a ^ b;
            fnSul: result = a << shamt;
            fnSsl: result = wordT'($signed(a) <<< shamt);
            fnSur: result = a >> shamt;
            fnSsr: result = wordT'($signed(a) >>> shamt);
            // Compares are signed, result in bit 0
            fnEq:  result = {31'b0, a == b};
            fnNeq: result = {31'b0, a != b};
            fnLt:  result = {31'b0, $signed(a) < $signed(b)};
            fnLeq: result = {31'b0, $signed(a) <= $signed(b)};
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/niuRegFile.sv ====
`timescale 1ns/100ps
`default_nettype none

module niuRegFile import niuPkg::*; (
    input  wire logic   clk,
    input  wire regIdxT readSel,
    input  wire regIdxT writeSel,
    input  wire logic   writeEn,
    input  wire wordT   writeData,
    output wordT        readData
);

    wordT regs [32];   // r0 is an ordinary register

    always_ff @(posedge clk) begin
        if (writeEn)
            regs[writeSel] <= writeData;
    end

    assign readData = regs[readSel];

endmodule

`default_nettype wire

// ==== design/niuControl.sv ====
`timescale 1ns/100ps
`default_nettype none

module niuControl import niuPkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    niuCtrlIf.control ctrl,
    output logic      halted
);

    typedef enum logic [4:0] {
        sFetch, sDecode,
        sAluB, sAluA, sAluWb,
        sMemBase, sMemOff, sMemAddr, sLdWait, sLdWb, sStore,
        sBrA, sBrB, sBrCmp, sBrPc, sBrImm, sBrAdd,
        sJalLink, sJalJump,
        sHalt
    } stateT;

    stateT   state, nextState;
    opcodeT  op1;
    aluFuncT op2;
    regIdxT  rx, ry, rz;
    logic    isRegOp;

    assign op1     = opcodeT'(ctrl.ir[31:27]);
    assign op2     = aluFuncT'(ctrl.ir[4:0]);
    assign rx      = ctrl.ir[26:22];
    assign ry      = ctrl.ir[21:17];
    assign rz      = ctrl.ir[16:12];
    assign isRegOp = (op1 == opAlu);
    assign halted  = (state == sHalt);

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            state <= sFetch;
        else
            state <= nextState;
    end

    always_comb begin
        ctrl.loadPc   = 1'b0;
        ctrl.incPc    = 1'b0;
        ctrl.loadIr   = 1'b0;
        ctrl.loadA    = 1'b0;
        ctrl.loadB    = 1'b0;
        ctrl.busSel   = busNone;
        ctrl.regSel   = rx;
        ctrl.regWrite = 1'b0;
        ctrl.aluFunc  = fnAdd;
        ctrl.loadMar  = 1'b0;
        ctrl.memWrite = 1'b0;
        nextState     = state;

        case (state)
            sFetch: begin
                ctrl.loadIr = 1'b1;
                ctrl.incPc  = 1'b1;
                nextState   = sDecode;
            end
            sDecode: begin
                case (op1)
                    opAlu, opAddi, opMlti, opAndi, opOri, opXori,
                    opSuli, opSsli, opSuri, opSsri: nextState = sAluB;
                    opLw, opSw:                     nextState = sMemBase;
                    opBeq, opBne, opBlt, opBle:     nextState = sBrA;
                    opJal:                          nextState = sJalLink;
                    default:                        nextState = sHalt;
                endcase
            end
            sAluB: begin
                ctrl.loadB  = 1'b1;
                ctrl.regSel = ry;
                ctrl.busSel = isRegOp ? busReg : busImm;
                nextState   = sAluA;
            end
            sAluA: begin
                ctrl.loadA  = 1'b1;
                ctrl.busSel = busReg;   // rx
                nextState   = sAluWb;
            end
            sAluWb: begin
                // Immediate opcodes reuse the secondary function codes
                ctrl.aluFunc  = isRegOp ? op2 : aluFuncT'(op1);
                ctrl.regSel   = isRegOp ? rz : ry;
                ctrl.busSel   = busAlu;
                ctrl.regWrite = 1'b1;
                nextState     = sFetch;
            end
            sMemBase: begin
                ctrl.loadA  = 1'b1;
                ctrl.busSel = busReg;
                nextState   = sMemOff;
            end
            sMemOff: begin
                ctrl.loadB  = 1'b1;
                ctrl.busSel = busImm;
                nextState   = sMemAddr;
            end
            sMemAddr: begin
                ctrl.busSel  = busAlu;
                ctrl.loadMar = 1'b1;
                nextState    = (op1 == opLw) ? sLdWait : sStore;
            end
            sLdWait: nextState = sLdWb;   // MDR fills from MAR
            sLdWb: begin
                ctrl.regSel   = ry;
                ctrl.busSel   = busMdr;
                ctrl.regWrite = 1'b1;
                nextState     = sFetch;
            end
            sStore: begin
                ctrl.regSel   = ry;
                ctrl.busSel   = busReg;
                ctrl.memWrite = 1'b1;
                nextState     = sFetch;
            end
            sBrA: begin
                ctrl.loadA  = 1'b1;
                ctrl.busSel = busReg;
                nextState   = sBrB;
            end
            sBrB: begin
                ctrl.loadB  = 1'b1;
                ctrl.regSel = ry;
                ctrl.busSel = busReg;
                nextState   = sBrCmp;
            end
            sBrCmp: begin
                case (op1)
                    opBne:   ctrl.aluFunc = fnNeq;
                    opBlt:   ctrl.aluFunc = fnLt;
                    opBle:   ctrl.aluFunc = fnLeq;
                    default: ctrl.aluFunc = fnEq;
                endcase
                nextState = ctrl.cond ? sBrPc : sFetch;
            end
            sBrPc: begin
                ctrl.loadA  = 1'b1;
                ctrl.busSel = busPc;   // Already incremented
                nextState   = sBrImm;
            end
            sBrImm: begin
                ctrl.loadB  = 1'b1;
                ctrl.busSel = busImmSh;
                nextState   = sBrAdd;
            end
            sBrAdd: begin
                ctrl.busSel = busAlu;
                ctrl.loadPc = 1'b1;
                nextState   = sFetch;
            end
            sJalLink: begin
                ctrl.regSel   = ry;
                ctrl.busSel   = busPc;
                ctrl.regWrite = 1'b1;
                nextState     = sJalJump;
            end
            sJalJump: begin
                ctrl.busSel = busReg;
                ctrl.loadPc = 1'b1;
                nextState   = sFetch;
            end
            default: nextState = sHalt;   // Halt never leaves
        endcase
    end

    // Once halted, only reset brings the core back
    haltSticky: assert property (@(posedge clk) disable iff (reset)
        halted |=> halted);

endmodule

`default_nettype wire

// ==== design/niuDatapath.sv ====
`timescale 1ns/100ps
`default_nettype none

module niuDatapath import niuPkg::*; (
    input  wire logic  clk,
    input  wire logic  reset,
    niuCtrlIf.datapath ctrl,
    niuMemIf.datapath  mem
);

    wordT pc;
    wordT ir;
    wordT a, b;
    wordT bus;
    wordT aluOut;
    wordT regData;
    wordT immExt;

    assign immExt = {{15{ir[16]}}, immT'(ir[16:0])};   // Sign-extend 17-bit field

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            pc <= pcStart;
        else if (ctrl.loadPc)
            pc <= bus;
        else if (ctrl.incPc)
            pc <= pc + instrBytes;
    end

    always_ff @(posedge clk) begin
        if (ctrl.loadIr)
            ir <= mem.instr;
        if (ctrl.loadA)
            a <= bus;
        if (ctrl.loadB)
            b <= bus;
    end

    // Single bus source
    always_comb begin
        case (ctrl.busSel)
            busPc:    bus = pc;
            busReg:   bus = regData;
            busImm:   bus = immExt;
            busImmSh: bus = immExt << 2;   // Word offset for branches
            busAlu:   bus = aluOut;
            busMdr:   bus = mem.mdr;
            default:  bus = '0;
        endcase
    end

    niuAlu u_alu (
        .a      (a),
        .b      (b),
        .func   (ctrl.aluFunc),
        .result (aluOut)
    );

    niuRegFile u_regFile (
        .clk       (clk),
        .readSel   (ctrl.regSel),
        .writeSel  (ctrl.regSel),
        .writeEn   (ctrl.regWrite),
        .writeData (bus),
        .readData  (regData)
    );

    assign ctrl.ir     = ir;
    assign ctrl.cond   = aluOut[0];
    assign mem.pc       = pc;
    assign mem.bus      = bus;
    assign mem.loadMar  = ctrl.loadMar;
    assign mem.memWrite = ctrl.memWrite;

    busSelKnown: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(ctrl.busSel));

endmodule

`default_nettype wire

// ==== design/niuMemory.sv ====
`timescale 1ns/100ps
`default_nettype none

module niuMemory import niuPkg::*; #(
    parameter int imemWords = 256,
    parameter int dmemWords = 256
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic imemWrite,
    input  wire wordT imemAddr,
    input  wire wordT imemData,
    niuMemIf.memory   mem,
    output logic      ioWrite,
    output wordT      ioData
);

    localparam int imemBits = $clog2(imemWords);
    localparam int dmemBits = $clog2(dmemWords);

    wordT imem [imemWords];
    wordT dmem [dmemWords];
    wordT mar;
    wordT mdr;
    logic isIo;

    // Word index above the two byte-offset bits
    always_ff @(posedge clk) begin
        if (imemWrite)
            imem[imemAddr[imemBits+1:2]] <= imemData;
    end

    assign mem.instr = imem[mem.pc[imemBits+1:2]];

    always_ff @(posedge clk) begin
        if (mem.loadMar)
            mar <= mem.bus;
        mdr <= dmem[mar[dmemBits+1:2]];   // Follows MAR by one edge
        if (mem.memWrite && !isIo)
            dmem[mar[dmemBits+1:2]] <= mem.bus;
    end

    assign mem.mdr = mdr;
    assign isIo    = (mar == ioAddr);
    assign ioWrite = mem.memWrite && isIo;   // Strobe in the store cycle
    assign ioData  = mem.bus;

    // Program load happens only under reset
    imemLoadInReset: assert property (@(posedge clk) imemWrite |-> reset);

endmodule

`default_nettype wire

// ==== design/niu32.sv ====
`timescale 1ns/100ps
`default_nettype none

module niu32 import niuPkg::*; #(
    parameter int imemWords = 256,
    parameter int dmemWords = 256
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic imemWrite,
    input  wire wordT imemAddr,
    input  wire wordT imemData,
    output logic      ioWrite,
    output wordT      ioData,
    output logic      halted
);

    niuCtrlIf ctrlBus ();
    niuMemIf  memBus ();

    niuControl u_control (
        .clk    (clk),
        .reset  (reset),
        .ctrl   (ctrlBus.control),
        .halted (halted)
    );

    niuDatapath u_datapath (
        .clk   (clk),
        .reset (reset),
        .ctrl  (ctrlBus.datapath),
        .mem   (memBus.datapath)
    );

    niuMemory #(
        .imemWords (imemWords),
        .dmemWords (dmemWords)
    ) u_memory (
        .clk       (clk),
        .reset     (reset),
        .imemWrite (imemWrite),
        .imemAddr  (imemAddr),
        .imemData  (imemData),
        .mem       (memBus.memory),
        .ioWrite   (ioWrite),
        .ioData    (ioData)
    );

endmodule

`default_nettype wire

// ==== include/niuTbModel.svh ====
`ifndef NIU_TB_MODEL_SVH
`define NIU_TB_MODEL_SVH

function automatic wordT rOp(logic [4:0] func, regIdxT rx, regIdxT ry, regIdxT rz);
    return {opAlu, rx, ry, rz, 7'b0, func};   // rz = rx func ry
endfunction

function automatic wordT iOp(logic [4:0] op, regIdxT rx, regIdxT ry, immT imm);
    return {op, rx, ry, imm};
endfunction

task automatic emit(input wordT w);
    progWords.push_back(w);
endtask

task automatic setConst(input regIdxT r, input immT imm);
    emit(iOp(opAddi, 5'd31, r, imm));   // r31 holds zero
endtask

task automatic storeIo(input regIdxT r);
    emit(iOp(opSw, 5'd31, r, 17'h10020));   // Sign-extends to the port address
endtask

// Full 32-bit random value from two random immediates
task automatic loadRandom(input regIdxT r);
    emit(iOp(opAddi, 5'd31, r, immT'($random(seed))));
    emit(iOp(opSuli, r, r, 17'd15));
    emit(iOp(opAddi, r, r, immT'($random(seed))));
endtask

task automatic branchTo(input logic [4:0] op, input regIdxT rx, input regIdxT ry,
                        input int target);
    emit(iOp(op, rx, ry, immT'(target - progWords.size() - 1)));
endtask

// Taken skips the tag word, so only tag+1 appears
task automatic branchBlock(input logic [4:0] op, input regIdxT rx, input regIdxT ry,
                           input immT tag);
    branchTo(op, rx, ry, progWords.size() + 3);
    setConst(5'd10, tag);
    storeIo(5'd10);
    setConst(5'd10, tag + 17'd1);
    storeIo(5'd10);
endtask

function automatic wordT aluRef(logic [4:0] func, wordT a, wordT b);
    logic [4:0] sh;
    sh = b[4:0];
    case (func)
        fnSub:   return a - b;
        fnAdd:   return a + b;
        fnMlt:   return a * b;   // Low word is the same signed or not
        fnNot:   return ~a;
        fnAnd:   return a & b;
        fnOr:    return a | b;
        fnXor:   return a ^ b;
        fnSul:   return a << sh;
        fnSsl:   return a << sh;
        fnSur:   return a >> sh;
        fnSsr:   return $signed(a) >>> sh;
        fnEq:    return wordT'(a == b);
        fnNeq:   return wordT'(a != b);
        fnLt:    return wordT'($signed(a) < $signed(b));
        fnLeq:   return wordT'($signed(a) <= $signed(b));
        default: return '0;
    endcase
endfunction

function automatic logic [4:0] immFunc(logic [4:0] op);
    case (op)
        opAddi:  return fnAdd;
        opMlti:  return fnMlt;
        opAndi:  return fnAnd;
        opOri:   return fnOr;
        opXori:  return fnXor;
        opSuli:  return fnSul;
        opSsli:  return fnSsl;
        opSuri:  return fnSur;
        default: return fnSsr;
    endcase
endfunction

function automatic logic branchTaken(logic [4:0] op, wordT a, wordT b);
    case (op)
        opBeq:   return a == b;
        opBne:   return a != b;
        opBlt:   return $signed(a) < $signed(b);
        default: return $signed(a) <= $signed(b);
    endcase
endfunction

// Instruction-level run of progWords; fills expWords, returns cycles up to halt
function automatic int refModel();
    wordT regs [32];
    wordT dmem [wordT];
    wordT pc;
    wordT w;
    wordT imm;
    wordT addr;
    logic [4:0] op;
    regIdxT rx, ry, rz;
    int cycles;
    int idx;
    pc = pcStart;
    cycles = 0;
    expWords.delete();
    for (int step = 0; step < 5000; step++) begin
        idx = int'(pc >> 2);
        if (idx >= progWords.size())
            return cycles;
        w = progWords[idx];
        op = w[31:27];
        rx = w[26:22];
        ry = w[21:17];
        rz = w[16:12];
        imm = {{15{w[16]}}, w[16:0]};
        pc = pc + 32'd4;
        case (op)
            opAlu: begin
                regs[rz] = aluRef(w[4:0], regs[rx], regs[ry]);
                cycles += 5;
            end
            opAddi, opMlti, opAndi, opOri, opXori, opSuli, opSsli, opSuri, opSsri: begin
                regs[ry] = aluRef(immFunc(op), regs[rx], imm);
                cycles += 5;
            end
            opLw: begin
                regs[ry] = dmem[regs[rx] + imm];
                cycles += 7;
            end
            opSw: begin
                addr = regs[rx] + imm;
                if (addr == ioAddr)
                    expWords.push_back(regs[ry]);
                else
                    dmem[addr] = regs[ry];
                cycles += 6;
            end
            opBeq, opBne, opBlt, opBle: begin
                if (branchTaken(op, regs[rx], regs[ry])) begin
                    pc = pc + (imm << 2);
                    cycles += 8;
                end else begin
                    cycles += 5;
                end
            end
            opJal: begin
                regs[ry] = pc;   // Link first, then read the target
                pc = regs[rx];
                cycles += 4;
            end
            default: return cycles + 2;   // Fetch and decode, then halt
        endcase
    end
    return cycles;
endfunction

`endif

// ==== tests/niu32Tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module niu32Tb import niuPkg::*; ;

    localparam int imemWords   = 256;
    localparam int dmemWords   = 256;
    localparam int slackCycles = 100;

    logic clk;
    logic reset;
    logic imemWrite;
    wordT imemAddr;
    wordT imemData;
    logic ioWrite;
    wordT ioData;
    logic halted;

    int   seed = 32'h57ff8c7b;
    wordT progWords[$];
    wordT expWords[$];
    int   expCycles;
    int   cycleCount;
    int   outIdx;

    `include "niuTbModel.svh"

    task automatic buildProgram();
        logic [4:0] regFuncs [15];
        logic [4:0] immOps [9];
        int loopTop;
        int callIdx;
        regFuncs = '{fnSub, fnAdd, fnMlt, fnNot, fnAnd, fnOr, fnXor, fnSul, fnSsl,
                     fnSur, fnSsr, fnEq, fnNeq, fnLt, fnLeq};
        immOps = '{opAddi, opMlti, opAndi, opOri, opXori, opSuli, opSsli, opSuri, opSsri};
        progWords.delete();
        emit(iOp(opAndi, 5'd31, 5'd31, 17'd0));   // r31 = 0
        loadRandom(5'd1);
        loadRandom(5'd2);
        foreach (regFuncs[i]) begin
            emit(rOp(regFuncs[i], 5'd1, 5'd2, 5'd3));
            storeIo(5'd3);
        end
        emit(rOp(fnEq, 5'd1, 5'd1, 5'd3));   // Equal operands for compares
        storeIo(5'd3);
        emit(rOp(fnLeq, 5'd2, 5'd2, 5'd3));
        storeIo(5'd3);
        foreach (immOps[i]) begin
            emit(iOp(immOps[i], 5'd1, 5'd3, immT'($random(seed)) | 17'h10000));   // Negative
            storeIo(5'd3);
        end

        // Data memory round trip
        setConst(5'd4, 17'h40);
        emit(iOp(opSw, 5'd4, 5'd1, 17'd0));
        emit(iOp(opSw, 5'd4, 5'd2, 17'd4));
        emit(iOp(opSw, 5'd4, 5'd3, 17'd8));
        emit(iOp(opLw, 5'd4, 5'd5, 17'd0));
        storeIo(5'd5);
        emit(iOp(opLw, 5'd4, 5'd5, 17'd4));
        storeIo(5'd5);
        setConst(5'd6, 17'h80);
        emit(iOp(opLw, 5'd6, 5'd5, immT'(-56)));   // Back down to 0x48
        storeIo(5'd5);

        setConst(5'd11, 17'd5);
        setConst(5'd12, 17'd7);
        setConst(5'd13, 17'd5);
        setConst(5'd14, immT'(-3));
        branchBlock(opBeq, 5'd11, 5'd13, 17'h100);
        branchBlock(opBeq, 5'd11, 5'd12, 17'h110);
        branchBlock(opBne, 5'd11, 5'd12, 17'h120);
        branchBlock(opBne, 5'd11, 5'd13, 17'h130);
        branchBlock(opBlt, 5'd11, 5'd12, 17'h140);
        branchBlock(opBlt, 5'd12, 5'd11, 17'h150);
        branchBlock(opBlt, 5'd14, 5'd11, 17'h160);   // Signed compare
        branchBlock(opBle, 5'd11, 5'd13, 17'h170);
        branchBlock(opBle, 5'd12, 5'd11, 17'h180);

        // Backward loops, counting up then down
        setConst(5'd15, 17'd0);
        setConst(5'd16, 17'd3);
        loopTop = progWords.size();
        emit(iOp(opAddi, 5'd15, 5'd15, 17'd1));
        storeIo(5'd15);
        branchTo(opBlt, 5'd15, 5'd16, loopTop);
        setConst(5'd17, 17'd2);
        loopTop = progWords.size();
        storeIo(5'd17);
        emit(iOp(opAddi, 5'd17, 5'd17, immT'(-1)));
        branchTo(opBne, 5'd17, 5'd31, loopTop);

        // Call a subroutine through JAL and return through the link
        callIdx = progWords.size();
        setConst(5'd20, immT'((callIdx + 4) * 4));
        emit(iOp(opJal, 5'd20, 5'd21, 17'd0));
        storeIo(5'd21);
        branchTo(opBeq, 5'd31, 5'd31, callIdx + 7);
        setConst(5'd10, 17'h5A5);
        storeIo(5'd10);
        emit(iOp(opJal, 5'd21, 5'd22, 17'd0));
        storeIo(5'd22);
        emit(32'hF000_0000);   // Undefined opcode 11110
    endtask

    niu32 #(
        .imemWords (imemWords),
        .dmemWords (dmemWords)
    ) u_dut (
        .clk       (clk),
        .reset     (reset),
        .imemWrite (imemWrite),
        .imemAddr  (imemAddr),
        .imemData  (imemData),
        .ioWrite   (ioWrite),
        .ioData    (ioData),
        .halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset covers the program load, then eight more cycles
    initial begin
        reset      = 1'b1;
        imemWrite  = 1'b0;
        imemAddr   = '0;
        imemData   = '0;
        cycleCount = 0;
        outIdx     = 0;
        buildProgram();
        expCycles = refModel();
        foreach (progWords[i]) begin
            @(posedge clk);
            #1;
            imemWrite = 1'b1;
            imemAddr  = wordT'(i * 4);
            imemData  = progWords[i];
        end
        @(posedge clk);
        #1;
        imemWrite = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic checkOutput(input wordT got);
        assert (outIdx < expWords.size())
        else failRun($sformatf("Output port written with %h after all expected words", got));
        assert (got == expWords[outIdx])
        else failRun($sformatf("FAILED at time %0t: output word %0d is %h, expected %h",
                               $time, outIdx, got, expWords[outIdx]));
        outIdx++;
    endtask

    task automatic finishRun();
        assert (cycleCount == expCycles)
        else failRun($sformatf("FAILED at time %0t: halted after %0d cycles, expected %0d",
                               $time, cycleCount, expCycles));
        assert (outIdx == expWords.size())
        else failRun($sformatf("Only %0d of %0d output words arrived before halt",
                               outIdx, expWords.size()));
        $display("All checks passed");
        $finish;
    endtask

    // Values sampled at the edge are the ones held through the cycle before it
    always @(posedge clk) begin
        if (!reset) begin
            if (ioWrite)
                checkOutput(ioData);
            if (halted) begin
                finishRun();
            end else begin
                cycleCount++;
                assert (cycleCount <= expCycles + slackCycles)
                else failRun($sformatf("Timeout: the core did not halt within %0d cycles",
                                       expCycles + slackCycles));
            end
        end
    end

endmodule

`default_nettype wire

// ==== niu32.f ====
+incdir+include
design/niuPkg.sv
design/niuCtrlIf.sv
design/niuMemIf.sv
design/niuAlu.sv
design/niuRegFile.sv
design/niuControl.sv
design/niuDatapath.sv
design/niuMemory.sv
design/niu32.sv
tests/niu32Tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= niu32Tb
FILELIST  ?= niu32.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --assert
SIMFLAGS  ?=

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST))) $(wildcard include/*.svh)
SIMBIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(SIMBIN)

$(SIMBIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIMBIN)
	./$(SIMBIN) $(SIMFLAGS)

clean:
	rm -rf $(OBJDIR)
